// ==== source/mac_fmt_pkg.sv ====
package mac_fmt_pkg;

	// operand and digit geometry
	localparam int OP_W       = 8;
	localparam int DIG_W      = 2;
	localparam int INT_DIGITS = 4;  // digits in an int8 magnitude
	localparam int FP_DIGITS  = 2;  // digits in an e4m3 significand

	// product side
	localparam int ACC_W  = 16;
	localparam int EXP_W  = 4;  // stored e4m3 exponent field
	localparam int EXPS_W = 5;  // sum of two effective exponents
	localparam int STEP_W = 2;

	typedef enum logic {
		MODE_INT8 = 1'b0,
		MODE_FP8  = 1'b1
	} mode_t;

endpackage

// ==== source/apb_map_pkg.sv ====
package apb_map_pkg;

	// register offsets
	localparam logic [7:0] OFF_CTRL   = 8'h00;
	localparam logic [7:0] OFF_OP_A   = 8'h04;
	localparam logic [7:0] OFF_OP_B   = 8'h08;
	localparam logic [7:0] OFF_STATUS = 8'h0C;
	localparam logic [7:0] OFF_RESULT = 8'h10;

	// ctrl fields, start is a write-only pulse
	localparam int CTRL_START_BIT = 0;
	localparam int CTRL_MODE_BIT  = 1;

	// status fields
	localparam int ST_BUSY_BIT = 0;
	localparam int ST_DONE_BIT = 1;

	// fp8 result word layout
	localparam int RES_EXP_LSB  = 8;
	localparam int RES_SIGN_BIT = 15;

endpackage

// ==== source/apb_regs.sv ====
`timescale 1ns/1ps

module apb_regs import mac_fmt_pkg::*, apb_map_pkg::*; #(
	parameter int ADDR_W = 8
) (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              psel_i,
	input  logic              penable_i,
	input  logic              pwrite_i,
	input  logic [ADDR_W-1:0] paddr_i,
	input  logic [31:0]       pwdata_i,
	input  logic              busy_i,
	input  logic [ACC_W-1:0]  result_i,
	input  logic              done_i,
	output logic [31:0]       prdata_o,
	output logic              pready_o,
	output logic              irq_o,
	output logic              start_o,
	output mode_t             mode_o,
	output logic [OP_W-1:0]   op_a_o,
	output logic [OP_W-1:0]   op_b_o
);

	logic access;
	logic wr_en;
	logic hit_ctrl, hit_op_a, hit_op_b, hit_status, hit_result;
	logic run_busy;
	logic start_go;
	logic done_q;

	assign hit_ctrl   = (paddr_i == ADDR_W'(OFF_CTRL));
	assign hit_op_a   = (paddr_i == ADDR_W'(OFF_OP_A));
	assign hit_op_b   = (paddr_i == ADDR_W'(OFF_OP_B));
	assign hit_status = (paddr_i == ADDR_W'(OFF_STATUS));
	assign hit_result = (paddr_i == ADDR_W'(OFF_RESULT));

	assign access   = psel_i & penable_i;
	assign run_busy = busy_i | start_o; // pending start counts as busy

	// result reads wait for the run to finish
	assign pready_o = ~(access & ~pwrite_i & hit_result & run_busy);
	assign wr_en    = access & pwrite_i & pready_o;
	assign start_go = wr_en & hit_ctrl & pwdata_i[CTRL_START_BIT] & ~run_busy;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			start_o <= 1'b0;
			done_q  <= 1'b0;
			mode_o  <= MODE_INT8;
		end else begin
			start_o <= start_go;
			if (start_go)
				done_q <= 1'b0;
			else if (done_i)
				done_q <= 1'b1;
			// mode is frozen while a run uses it
			if (wr_en && hit_ctrl && !run_busy)
				mode_o <= mode_t'(pwdata_i[CTRL_MODE_BIT]);
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_en && hit_op_a)
			op_a_o <= pwdata_i[OP_W-1:0];
		if (wr_en && hit_op_b)
			op_b_o <= pwdata_i[OP_W-1:0];
	end

	assign irq_o = done_q;

	always_comb begin
		prdata_o = '0;
		if (hit_ctrl) begin
			prdata_o[CTRL_MODE_BIT] = mode_o;
		end else if (hit_op_a) begin
			prdata_o[OP_W-1:0] = op_a_o;
		end else if (hit_op_b) begin
			prdata_o[OP_W-1:0] = op_b_o;
		end else if (hit_status) begin
			prdata_o[ST_BUSY_BIT] = run_busy;
			prdata_o[ST_DONE_BIT] = done_q;
		end else if (hit_result) begin
			prdata_o[ACC_W-1:0] = result_i;
		end
	end

endmodule

// ==== source/seq_fsm.sv ====
`timescale 1ns/1ps

module seq_fsm (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic start_i,
	input  logic last_i,
	output logic load_o,
	output logic clr_o,
	output logic step_en_o,
	output logic finish_o,
	output logic busy_o
);

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		RUN,
		FINISH
	} state_t;

	state_t state_q, state_d;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE:    if (start_i) state_d = LOAD;
			LOAD:    state_d = RUN;
			RUN:     if (last_i) state_d = FINISH; // last row accumulates on this edge
			FINISH:  state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			state_q <= IDLE;
		else
			state_q <= state_d;
	end

	// load also clears counter and accumulator
	assign load_o    = (state_q == LOAD);
	assign clr_o     = (state_q == LOAD);
	assign step_en_o = (state_q == RUN);
	assign finish_o  = (state_q == FINISH);
	assign busy_o    = (state_q != IDLE);

endmodule

// ==== source/digit_counter.sv ====
`timescale 1ns/1ps

module digit_counter import mac_fmt_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              clr_i,
	input  logic              en_i,
	input  mode_t             mode_i,
	output logic [STEP_W-1:0] idx_o,
	output logic              last_o
);

	logic [STEP_W-1:0] last_idx;

	// fp8 significand has only two digits
	assign last_idx = (mode_i == MODE_FP8) ? STEP_W'(FP_DIGITS - 1) : STEP_W'(INT_DIGITS - 1);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			idx_o <= '0;
		else if (clr_i)
			idx_o <= '0;
		else if (en_i)
			idx_o <= idx_o + 1'b1;
	end

	assign last_o = en_i & (idx_o == last_idx);

endmodule

// ==== source/operand_unpack.sv ====
`timescale 1ns/1ps

module operand_unpack import mac_fmt_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              load_i,
	input  mode_t             mode_i,
	input  logic [OP_W-1:0]   op_a_i,
	input  logic [OP_W-1:0]   op_b_i,
	output logic [OP_W-1:0]   mag_a_o,
	output logic [OP_W-1:0]   mag_b_o,
	output logic              sign_o,
	output logic [EXPS_W-1:0] exp_sum_o
);

	localparam int MAN_W = OP_W - 1 - EXP_W;

	logic [OP_W-1:0]   mag_a_d, mag_b_d;
	logic [EXPS_W-1:0] exp_sum_d;

	function automatic logic [OP_W-1:0] int_mag(input logic [OP_W-1:0] v);
		return v[OP_W-1] ? (~v) + 1'b1 : v;
	endfunction

	// implicit one only for a nonzero exponent field
	function automatic logic [OP_W-1:0] fp_sig(input logic [OP_W-1:0] v);
		logic hidden;
		hidden = |v[OP_W-2 -: EXP_W];
		return {{(OP_W-MAN_W-1){1'b0}}, hidden, v[MAN_W-1:0]};
	endfunction

	function automatic logic [EXP_W-1:0] fp_exp(input logic [OP_W-1:0] v);
		logic [EXP_W-1:0] e;
		e = v[OP_W-2 -: EXP_W];
		return (e == '0) ? EXP_W'(1) : e; // subnormal sits at exponent 1
	endfunction

	always_comb begin
		if (mode_i == MODE_FP8) begin
			mag_a_d   = fp_sig(op_a_i);
			mag_b_d   = fp_sig(op_b_i);
			exp_sum_d = EXPS_W'(fp_exp(op_a_i)) + EXPS_W'(fp_exp(op_b_i));
		end else begin
			mag_a_d   = int_mag(op_a_i);
			mag_b_d   = int_mag(op_b_i);
			exp_sum_d = '0;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mag_a_o   <= '0;
			mag_b_o   <= '0;
			sign_o    <= 1'b0;
			exp_sum_o <= '0;
		end else if (load_i) begin
			mag_a_o   <= mag_a_d;
			mag_b_o   <= mag_b_d;
			sign_o    <= op_a_i[OP_W-1] ^ op_b_i[OP_W-1]; // msb is the sign in both formats
			exp_sum_o <= exp_sum_d;
		end
	end

endmodule

// ==== source/digit_mul_row.sv ====
`timescale 1ns/1ps

module digit_mul_row import mac_fmt_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              clr_i,
	input  logic              en_i,
	input  logic [OP_W-1:0]   mag_a_i,
	input  logic [OP_W-1:0]   mag_b_i,
	input  logic [STEP_W-1:0] idx_i,
	output logic [ACC_W-1:0]  acc_o
);

	logic [DIG_W-1:0]   b_dig;
	logic [2*DIG_W-1:0] pp [INT_DIGITS];
	logic [ACC_W-1:0]   row;

	assign b_dig = mag_b_i[idx_i*DIG_W +: DIG_W];

	// one 2x2 digit multiplier per digit of a
	for (genvar j = 0; j < INT_DIGITS; j++) begin : g_dmul
		assign pp[j] = mag_a_i[j*DIG_W +: DIG_W] * b_dig;
	end

	always_comb begin
		row = '0;
		for (int j = 0; j < INT_DIGITS; j++)
			row = row + (ACC_W'(pp[j]) << (j*DIG_W));
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			acc_o <= '0;
		else if (clr_i)
			acc_o <= '0;
		else if (en_i)
			acc_o <= acc_o + (row << (idx_i*DIG_W)); // row weight follows digit of b
	end

endmodule

// ==== source/result_pack.sv ====
`timescale 1ns/1ps

module result_pack import mac_fmt_pkg::*, apb_map_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              finish_i,
	input  mode_t             mode_i,
	input  logic [ACC_W-1:0]  acc_i,
	input  logic              sign_i,
	input  logic [EXPS_W-1:0] exp_sum_i,
	output logic [ACC_W-1:0]  result_o,
	output logic              done_o
);

	logic [ACC_W-1:0] int_word;
	logic [ACC_W-1:0] fp_word;

	assign int_word = sign_i ? (~acc_i) + 1'b1 : acc_i;

	// unnormalized significand product below the exponent field
	always_comb begin
		fp_word = '0;
		fp_word[RES_EXP_LSB-1:0]        = acc_i[RES_EXP_LSB-1:0];
		fp_word[RES_EXP_LSB +: EXPS_W]  = exp_sum_i;
		fp_word[RES_SIGN_BIT]           = sign_i;
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			result_o <= '0;
		else if (finish_i)
			result_o <= (mode_i == MODE_FP8) ? fp_word : int_word;
	end

	// done lands on the same edge as the stored result
	assign done_o = finish_i;

endmodule

// ==== source/mac_top.sv ====
`timescale 1ns/1ps

module mac_top import mac_fmt_pkg::*; #(
	parameter int ADDR_W = 8
) (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              psel_i,
	input  logic              penable_i,
	input  logic              pwrite_i,
	input  logic [ADDR_W-1:0] paddr_i,
	input  logic [31:0]       pwdata_i,
	output logic [31:0]       prdata_o,
	output logic              pready_o,
	output logic              irq_o
);

	logic              start, busy, done;
	logic              load, clr, step_en, finish, last;
	mode_t             mode;
	logic [OP_W-1:0]   op_a, op_b;
	logic [OP_W-1:0]   mag_a, mag_b;
	logic              sign;
	logic [EXPS_W-1:0] exp_sum;
	logic [STEP_W-1:0] idx;
	logic [ACC_W-1:0]  acc, result;

	apb_regs #(.ADDR_W(ADDR_W)) u_regs (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
		.paddr_i(paddr_i), .pwdata_i(pwdata_i),
		.busy_i(busy), .result_i(result), .done_i(done),
		.prdata_o(prdata_o), .pready_o(pready_o), .irq_o(irq_o),
		.start_o(start), .mode_o(mode), .op_a_o(op_a), .op_b_o(op_b)
	);

	seq_fsm u_fsm (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .start_i(start), .last_i(last),
		.load_o(load), .clr_o(clr), .step_en_o(step_en), .finish_o(finish), .busy_o(busy)
	);

	digit_counter u_cnt (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .clr_i(clr), .en_i(step_en), .mode_i(mode),
		.idx_o(idx), .last_o(last)
	);

	operand_unpack u_unpack (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .load_i(load), .mode_i(mode),
		.op_a_i(op_a), .op_b_i(op_b),
		.mag_a_o(mag_a), .mag_b_o(mag_b), .sign_o(sign), .exp_sum_o(exp_sum)
	);

	digit_mul_row u_row (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .clr_i(clr), .en_i(step_en),
		.mag_a_i(mag_a), .mag_b_i(mag_b), .idx_i(idx), .acc_o(acc)
	);

	result_pack u_pack (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .finish_i(finish), .mode_i(mode),
		.acc_i(acc), .sign_i(sign), .exp_sum_i(exp_sum),
		.result_o(result), .done_o(done)
	);

endmodule

// ==== verification/mac_props.sv ====
`timescale 1ns/1ps

module mac_props import apb_map_pkg::*; #(
	parameter int ADDR_W = 8
) (
	input logic              clk_i,
	input logic              rst_n_i,
	input logic              psel_i,
	input logic              penable_i,
	input logic              pwrite_i,
	input logic [ADDR_W-1:0] paddr_i,
	input logic [31:0]       pwdata_i,
	input logic              pready_i,
	input logic              irq_i,
	input logic              busy_i,
	input logic              start_i
);

	int   fail_cnt = 0;
	logic access;
	logic start_wr;

	assign access = psel_i & penable_i;
	// start write that actually launches a run
	assign start_wr = access & pwrite_i & pready_i & (paddr_i == ADDR_W'(OFF_CTRL))
		& pwdata_i[CTRL_START_BIT] & ~busy_i & ~start_i;

	a_wait_only_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		access && !pready_i |-> !pwrite_i && paddr_i == ADDR_W'(OFF_RESULT))
		else begin
			fail_cnt++;
			$error("pready_o went low outside a read of the result register");
		end

	a_hold_in_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		access && !pready_i |=> psel_i && penable_i && $stable(pwrite_i)
			&& $stable(paddr_i) && $stable(pwdata_i))
		else begin
			fail_cnt++;
			$error("apb inputs changed during a wait state");
		end

	a_irq_cleared: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		start_wr |=> !irq_i)
		else begin
			fail_cnt++;
			$error("irq_o still high after a start write");
		end

	a_int8_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		start_wr && !pwdata_i[CTRL_MODE_BIT] |-> ##1 (!irq_i)[*7] ##1 irq_i)
		else begin
			fail_cnt++;
			$error("irq_o did not rise 7 cycles after an int8 start");
		end

	a_fp8_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		start_wr && pwdata_i[CTRL_MODE_BIT] |-> ##1 (!irq_i)[*5] ##1 irq_i)
		else begin
			fail_cnt++;
			$error("irq_o did not rise 5 cycles after an fp8 start");
		end

endmodule

// ==== verification/tb_mac_top.sv ====
`timescale 1ns/1ps

module tb_mac_top import mac_fmt_pkg::*, apb_map_pkg::*;;

	localparam int ADDR_W     = 8;
	localparam int NUM_OPS    = 25 + 16 + 6 + 12 + 2 + 2; // busy test counts twice
	localparam int OP_CYCLES  = 16; // three writes, status polls, result read
	localparam int MAX_CYCLES = 2 * NUM_OPS * OP_CYCLES + 20;

	logic              clk;
	logic              rst_n;
	logic              psel, penable, pwrite;
	logic [ADDR_W-1:0] paddr;
	logic [31:0]       pwdata;
	logic [31:0]       prdata;
	logic              pready;
	logic              irq;

	int err_cnt;
	int cycles;
	int seed;

	logic [7:0] corner [5] = '{8'h00, 8'h01, 8'hFF, 8'h7F, 8'h80};
	logic [7:0] fp_a   [6] = '{8'h38, 8'h00, 8'h01, 8'hFF, 8'h85, 8'h07};
	logic [7:0] fp_b   [6] = '{8'h38, 8'h38, 8'h7F, 8'hFF, 8'h42, 8'h87};

	mac_top #(.ADDR_W(ADDR_W)) UUT (
		.clk_i(clk), .rst_n_i(rst_n),
		.psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
		.paddr_i(paddr), .pwdata_i(pwdata),
		.prdata_o(prdata), .pready_o(pready), .irq_o(irq)
	);

	bind mac_top mac_props #(.ADDR_W(ADDR_W)) u_props (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
		.paddr_i(paddr_i), .pwdata_i(pwdata_i),
		.pready_i(pready_o), .irq_i(irq_o), .busy_i(busy), .start_i(start)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic check_val(input string name, input logic [31:0] exp_v,
		input logic [31:0] got);
		assert (got === exp_v) else begin
			err_cnt++;
			$display("mismatch at %0t ns: %s expected %h actual %h", $time, name, exp_v, got);
		end
	endtask

	// starts 1 ns after an edge and returns 1 ns after the completing edge
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata);
		logic ready;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		ready   = 1'b0;
		while (!ready) begin
			@(negedge clk); // pready and prdata settled here
			ready = pready;
			rdata = prdata;
			@(posedge clk);
		end
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
		logic [31:0] unused;
		apb_xfer(1'b1, addr, wdata, unused);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata);
		apb_xfer(1'b0, addr, 32'h0, rdata);
	endtask

	function automatic logic [31:0] ctrl_word(input mode_t mode);
		logic [31:0] w;
		w = '0;
		w[CTRL_START_BIT] = 1'b1;
		w[CTRL_MODE_BIT]  = mode;
		return w;
	endfunction

	function automatic logic [31:0] int8_expect(input logic [7:0] a, input logic [7:0] b);
		int prod;
		prod = int'($signed(a)) * int'($signed(b));
		return {16'h0, prod[15:0]};
	endfunction

	// unnormalized significand product, effective exponent sum, sign
	function automatic logic [31:0] fp8_expect(input logic [7:0] a, input logic [7:0] b);
		logic [31:0] w;
		int ea, eb, sa, sb;
		ea = a[6:3];
		eb = b[6:3];
		sa = (ea == 0) ? a[2:0] : 8 + a[2:0];
		sb = (eb == 0) ? b[2:0] : 8 + b[2:0];
		if (ea == 0)
			ea = 1;
		if (eb == 0)
			eb = 1;
		w = '0;
		w[7:0] = 8'(sa * sb);
		w[RES_EXP_LSB +: 5] = 5'(ea + eb);
		w[RES_SIGN_BIT] = a[7] ^ b[7];
		return w;
	endfunction

	task automatic wait_done();
		logic [31:0] st;
		st = '0;
		while (!st[ST_DONE_BIT])
			apb_read(OFF_STATUS, st);
		check_val("status busy", 32'd0, {31'b0, st[ST_BUSY_BIT]});
		check_val("irq_o", 32'd1, {31'b0, irq});
	endtask

	task automatic start_run(input mode_t mode, input logic [7:0] a, input logic [7:0] b);
		apb_write(OFF_OP_A, {24'h0, a});
		apb_write(OFF_OP_B, {24'h0, b});
		apb_write(OFF_CTRL, ctrl_word(mode));
		check_val("irq_o", 32'd0, {31'b0, irq});
	endtask

	// poll low reads the result at once and leans on the wait states
	task automatic run_op(input mode_t mode, input logic [7:0] a, input logic [7:0] b,
		input logic poll);
		logic [31:0] rd;
		logic [31:0] exp_v;
		exp_v = (mode == MODE_FP8) ? fp8_expect(a, b) : int8_expect(a, b);
		start_run(mode, a, b);
		if (poll)
			wait_done();
		apb_read(OFF_RESULT, rd);
		check_val("prdata_o", exp_v, rd);
		check_val("irq_o", 32'd1, {31'b0, irq});
	endtask

	task automatic start_while_busy(input logic [7:0] a1, input logic [7:0] b1,
		input logic [7:0] a2, input logic [7:0] b2);
		logic [31:0] rd;
		start_run(MODE_INT8, a1, b1);
		start_run(MODE_FP8, a2, b2); // lands mid-run with another mode and must be dropped
		wait_done();
		apb_read(OFF_RESULT, rd);
		check_val("prdata_o", int8_expect(a1, b1), rd);
		apb_read(OFF_STATUS, rd);
		check_val("status busy", 32'd0, {31'b0, rd[ST_BUSY_BIT]});
	endtask

	initial begin
		clk     = 1'b0;
		rst_n   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		err_cnt = 0;
		cycles  = 0;
		seed    = 93;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_val("irq_o", 32'd0, {31'b0, irq});
		check_val("pready_o", 32'd1, {31'b0, pready});

		for (int i = 0; i < 5; i++)
			for (int j = 0; j < 5; j++)
				run_op(MODE_INT8, corner[i], corner[j], 1'b1);
		repeat (16)
			run_op(MODE_INT8, 8'($random(seed)), 8'($random(seed)), 1'b1);

		for (int i = 0; i < 6; i++)
			run_op(MODE_FP8, fp_a[i], fp_b[i], 1'b1);
		repeat (12)
			run_op(MODE_FP8, 8'($random(seed)), 8'($random(seed)), 1'b1);

		run_op(MODE_INT8, 8'($random(seed)), 8'($random(seed)), 1'b0);
		run_op(MODE_FP8, 8'($random(seed)), 8'($random(seed)), 1'b0);
		start_while_busy(8'h93, 8'hC5, 8'h11, 8'h22);

		$display("errors: %0d check failures, %0d assertion failures",
			err_cnt, UUT.u_props.fail_cnt);
		if (err_cnt == 0 && UUT.u_props.fail_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== tb.f ====
source/mac_fmt_pkg.sv
source/apb_map_pkg.sv
source/apb_regs.sv
source/seq_fsm.sv
source/digit_counter.sv
source/operand_unpack.sv
source/digit_mul_row.sv
source/result_pack.sv
source/mac_top.sv
verification/mac_props.sv
verification/tb_mac_top.sv
